// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// machine word and register file size
`define CPU_WORD_W   16
`define CPU_NUM_REGS 4

// first fetch address after reset
`define CPU_RESET_PC 0

// instruction fields
`define CPU_OPC_MSB   15
`define CPU_OPC_LSB   12
`define CPU_RS_MSB    11
`define CPU_RS_LSB    10
`define CPU_RT_MSB    9
`define CPU_RT_LSB    8
`define CPU_RD_MSB    7
`define CPU_RD_LSB    6
`define CPU_FUNCT_MSB 5
`define CPU_FUNCT_LSB 0
`define CPU_IMM_MSB   7
`define CPU_IMM_LSB   0
`define CPU_TGT_MSB   11
`define CPU_TGT_LSB   0

`endif

// ==== cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

	// major opcodes, 15 is the R-type and system group
	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_JR  = 6'd25,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} funct_e;

	// pass-high puts the immediate in the upper byte
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_NOT    = 3'd4,
		ALU_LHI    = 3'd5,
		ALU_PASS_B = 3'd6
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;
		logic    pc_to_reg;
		logic    is_br_ne;
		logic    is_br_eq;
		logic    is_jmp;
		logic    is_jr;
		logic    is_wwd;
		logic    is_halt;
		logic    valid;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc_plus1;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		ctrl_t                          ctrl;
		word_t                          op_a;
		word_t                          op_b;
		word_t                          imm;
		word_t                          pc_plus1;
		logic [`CPU_TGT_MSB:`CPU_TGT_LSB] jfield;
		reg_idx_t                       dest;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    alu_res;
		word_t    st_data;
		word_t    pc_plus1;
		reg_idx_t dest;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    alu_res;
		word_t    ld_data;
		word_t    pc_plus1;
		reg_idx_t dest;
	} mem_wb_t;

endpackage

// ==== pipe_latch.sv ====
`timescale 1ns/1ps

module pipe_latch #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_stall,
	input  logic i_flush,
	input  T     i_d,
	output T     o_q
);

	// an all-zero payload is a bubble, valid bit low
	always_ff @(posedge clk) begin
		if (i_reset || i_flush) begin
			o_q <= '0;
		end else if (!i_stall) begin
			o_q <= i_d;
		end
	end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
	input  logic            clk,
	input  logic            i_reset,
	input  logic            i_stall,
	input  logic            i_halt,
	input  logic            i_redirect,
	input  cpu_pkg::word_t  i_target,
	input  cpu_pkg::word_t  i_data1,
	output logic            o_read_m1,
	output cpu_pkg::word_t  o_address1,
	output cpu_pkg::if_id_t o_if
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_plus1;
	logic  fetched_hlt;

	assign pc_plus1 = pc + word_t'(1);
	assign o_address1 = pc;

	// HLT parks the pc, so only copies of it follow into the pipe
	assign fetched_hlt = o_read_m1 &&
		(opcode_e'(i_data1[`CPU_OPC_MSB:`CPU_OPC_LSB]) == OP_RTYPE) &&
		(funct_e'(i_data1[`CPU_FUNCT_MSB:`CPU_FUNCT_LSB]) == FN_HLT);

	// read port comes up one cycle after reset
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_read_m1 <= 1'b0;
		end else begin
			o_read_m1 <= !i_halt;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			pc <= word_t'(`CPU_RESET_PC);
		end else if (i_redirect) begin
			pc <= i_target;
		end else if (o_read_m1 && !i_stall && !i_halt && !fetched_hlt) begin
			pc <= pc_plus1;
		end
	end

	assign o_if = '{instr: i_data1, pc_plus1: pc_plus1, valid: o_read_m1};

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
	input  cpu_pkg::if_id_t   i_if,
	input  cpu_pkg::word_t    i_rdata1,
	input  cpu_pkg::word_t    i_rdata2,
	input  cpu_pkg::reg_idx_t i_ex_dest,
	input  logic              i_ex_writes,
	input  cpu_pkg::reg_idx_t i_mem_dest,
	input  logic              i_mem_writes,
	output cpu_pkg::reg_idx_t o_raddr1,
	output cpu_pkg::reg_idx_t o_raddr2,
	output cpu_pkg::id_ex_t   o_id,
	output logic              o_stall
);
	import cpu_pkg::*;

	localparam int IMM_W = `CPU_IMM_MSB - `CPU_IMM_LSB + 1;

	opcode_e           opcode;
	funct_e            funct;
	reg_idx_t          rs;
	reg_idx_t          rt;
	reg_idx_t          rd;
	logic [IMM_W-1:0]  imm8;
	word_t             imm_ext;
	ctrl_t             ctrl;
	reg_idx_t          dest;
	logic              uses_rs;
	logic              uses_rt;
	logic              zero_ext;
	logic              rs_hit;
	logic              rt_hit;

	assign opcode = opcode_e'(i_if.instr[`CPU_OPC_MSB:`CPU_OPC_LSB]);
	assign funct = funct_e'(i_if.instr[`CPU_FUNCT_MSB:`CPU_FUNCT_LSB]);
	assign rs = i_if.instr[`CPU_RS_MSB:`CPU_RS_LSB];
	assign rt = i_if.instr[`CPU_RT_MSB:`CPU_RT_LSB];
	assign rd = i_if.instr[`CPU_RD_MSB:`CPU_RD_LSB];
	assign imm8 = i_if.instr[`CPU_IMM_MSB:`CPU_IMM_LSB];

	assign o_raddr1 = rs;
	// WWD reads rs on port 2 as well, the ALU passes it through
	assign o_raddr2 = (opcode == OP_RTYPE && funct == FN_WWD) ? rs : rt;

	always_comb begin
		ctrl = '0;
		ctrl.valid = i_if.valid;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		zero_ext = 1'b0;
		dest = rt;
		case (opcode)
			OP_ADI: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				uses_rs = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op = ALU_OR;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				uses_rs = 1'b1;
				zero_ext = 1'b1;
			end
			OP_LHI: begin
				ctrl.alu_op = ALU_LHI;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_LWD: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				uses_rs = 1'b1;
			end
			OP_SWD: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			OP_BNE, OP_BEQ: begin
				ctrl.alu_op = ALU_SUB;
				ctrl.is_br_ne = (opcode == OP_BNE);
				ctrl.is_br_eq = (opcode == OP_BEQ);
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			OP_JMP: begin
				ctrl.is_jmp = 1'b1;
			end
			OP_JAL: begin
				// link register is r2
				ctrl.is_jmp = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.pc_to_reg = 1'b1;
				dest = reg_idx_t'(2);
			end
			OP_RTYPE: begin
				dest = rd;
				case (funct)
					FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
						ctrl.reg_write = 1'b1;
						uses_rs = 1'b1;
						uses_rt = 1'b1;
						if (funct == FN_SUB) ctrl.alu_op = ALU_SUB;
						if (funct == FN_AND) ctrl.alu_op = ALU_AND;
						if (funct == FN_ORR) ctrl.alu_op = ALU_OR;
					end
					FN_NOT: begin
						ctrl.alu_op = ALU_NOT;
						ctrl.reg_write = 1'b1;
						uses_rs = 1'b1;
					end
					FN_JR: begin
						ctrl.is_jr = 1'b1;
						uses_rs = 1'b1;
					end
					FN_WWD: begin
						ctrl.alu_op = ALU_PASS_B;
						ctrl.is_wwd = 1'b1;
						uses_rs = 1'b1;
					end
					FN_HLT: begin
						ctrl.is_halt = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	// ORI zero-extends, every other immediate is signed
	assign imm_ext = zero_ext ? {{(`CPU_WORD_W-IMM_W){1'b0}}, imm8}
		: {{(`CPU_WORD_W-IMM_W){imm8[IMM_W-1]}}, imm8};

	// RAW against the two stages ahead, writeback is covered by write-through
	assign rs_hit = (i_ex_writes && i_ex_dest == rs) || (i_mem_writes && i_mem_dest == rs);
	assign rt_hit = (i_ex_writes && i_ex_dest == rt) || (i_mem_writes && i_mem_dest == rt);
	assign o_stall = i_if.valid && ((uses_rs && rs_hit) || (uses_rt && rt_hit));

	assign o_id = '{
		ctrl: ctrl,
		op_a: i_rdata1,
		op_b: i_rdata2,
		imm: imm_ext,
		pc_plus1: i_if.pc_plus1,
		jfield: i_if.instr[`CPU_TGT_MSB:`CPU_TGT_LSB],
		dest: dest
	};

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
	input  logic              clk,
	input  logic              i_reset,
	input  cpu_pkg::reg_idx_t i_raddr1,
	input  cpu_pkg::reg_idx_t i_raddr2,
	input  logic              i_we,
	input  cpu_pkg::reg_idx_t i_waddr,
	input  cpu_pkg::word_t    i_wdata,
	output cpu_pkg::word_t    o_rdata1,
	output cpu_pkg::word_t    o_rdata2
);
	import cpu_pkg::*;

	word_t regs [`CPU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// write-through so decode sees this cycle's writeback
	assign o_rdata1 = (i_we && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
	assign o_rdata2 = (i_we && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
	input  cpu_pkg::id_ex_t  i_id,
	output cpu_pkg::ex_mem_t o_ex,
	output logic             o_redirect,
	output cpu_pkg::word_t   o_target
);
	import cpu_pkg::*;

	word_t operand_b;
	word_t alu_out;
	logic  taken;
	word_t jmp_target;
	word_t br_target;

	assign operand_b = i_id.ctrl.use_imm ? i_id.imm : i_id.op_b;

	always_comb begin
		case (i_id.ctrl.alu_op)
			ALU_ADD: begin
				alu_out = i_id.op_a + operand_b;
			end
			ALU_SUB: begin
				alu_out = i_id.op_a - operand_b;
			end
			ALU_AND: begin
				alu_out = i_id.op_a & operand_b;
			end
			ALU_OR: begin
				alu_out = i_id.op_a | operand_b;
			end
			ALU_NOT: begin
				alu_out = ~i_id.op_a;
			end
			ALU_LHI: begin
				alu_out = operand_b << 8;
			end
			default: begin
				alu_out = operand_b;
			end
		endcase
	end

	// branch compares the two registers, not the ALU result
	assign taken = (i_id.ctrl.is_br_ne && i_id.op_a != i_id.op_b) ||
		(i_id.ctrl.is_br_eq && i_id.op_a == i_id.op_b);

	assign jmp_target = {i_id.pc_plus1[`CPU_WORD_W-1:`CPU_TGT_MSB+1], i_id.jfield};
	assign br_target = i_id.pc_plus1 + i_id.imm;

	always_comb begin
		if (i_id.ctrl.is_jr) begin
			o_target = i_id.op_a;
		end else if (i_id.ctrl.is_jmp) begin
			o_target = jmp_target;
		end else begin
			o_target = br_target;
		end
	end

	// not-taken is the prediction, so only a taken transfer redirects
	assign o_redirect = i_id.ctrl.valid &&
		(taken || i_id.ctrl.is_jmp || i_id.ctrl.is_jr);

	assign o_ex = '{
		ctrl: i_id.ctrl,
		alu_res: alu_out,
		st_data: i_id.op_b,
		pc_plus1: i_id.pc_plus1,
		dest: i_id.dest
	};

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
	input  logic              clk,
	input  logic              i_reset,
	input  cpu_pkg::ex_mem_t  i_mem,
	input  cpu_pkg::word_t    i_data2,
	input  cpu_pkg::mem_wb_t  i_wb,
	output logic              o_read_m2,
	output logic              o_write_m2,
	output cpu_pkg::word_t    o_address2,
	output cpu_pkg::word_t    o_wdata2,
	output cpu_pkg::mem_wb_t  o_mem_wb,
	output logic              o_we,
	output cpu_pkg::reg_idx_t o_waddr,
	output cpu_pkg::word_t    o_wdata,
	output cpu_pkg::word_t    o_num_inst,
	output cpu_pkg::word_t    o_output_port,
	output logic              o_is_halted
);
	import cpu_pkg::*;

	logic retire;

	// memory stage, the load data comes back in the same cycle
	assign o_read_m2 = i_mem.ctrl.valid && i_mem.ctrl.mem_read;
	assign o_write_m2 = i_mem.ctrl.valid && i_mem.ctrl.mem_write;
	assign o_address2 = i_mem.alu_res;
	assign o_wdata2 = i_mem.st_data;

	assign o_mem_wb = '{
		ctrl: i_mem.ctrl,
		alu_res: i_mem.alu_res,
		ld_data: i_data2,
		pc_plus1: i_mem.pc_plus1,
		dest: i_mem.dest
	};

	// the HLT copies behind the first one never retire
	assign retire = i_wb.ctrl.valid && !o_is_halted;
	assign o_we = retire && i_wb.ctrl.reg_write;
	assign o_waddr = i_wb.dest;

	always_comb begin
		if (i_wb.ctrl.pc_to_reg) begin
			o_wdata = i_wb.pc_plus1;
		end else if (i_wb.ctrl.mem_to_reg) begin
			o_wdata = i_wb.ld_data;
		end else begin
			o_wdata = i_wb.alu_res;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_num_inst <= '0;
			o_output_port <= '0;
			o_is_halted <= 1'b0;
		end else if (retire) begin
			o_num_inst <= o_num_inst + word_t'(1);
			if (i_wb.ctrl.is_wwd) begin
				o_output_port <= i_wb.alu_res;
			end
			if (i_wb.ctrl.is_halt) begin
				o_is_halted <= 1'b1;
			end
		end
	end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
	input  logic           clk,
	input  logic           i_reset,
	output logic           o_read_m1,
	output cpu_pkg::word_t o_address1,
	input  cpu_pkg::word_t i_data1,
	output logic           o_read_m2,
	output logic           o_write_m2,
	output cpu_pkg::word_t o_address2,
	input  cpu_pkg::word_t i_data2,
	output cpu_pkg::word_t o_wdata2,
	output cpu_pkg::word_t o_num_inst,
	output cpu_pkg::word_t o_output_port,
	output logic           o_is_halted
);
	import cpu_pkg::*;

	// stage payloads, d side from the producer and q side from the latch
	if_id_t  if_d;
	if_id_t  if_q;
	id_ex_t  id_d;
	id_ex_t  id_q;
	ex_mem_t ex_d;
	ex_mem_t ex_q;
	mem_wb_t wb_d;
	mem_wb_t wb_q;

	logic     stall;
	logic     redirect;
	word_t    target;
	reg_idx_t raddr1;
	reg_idx_t raddr2;
	word_t    rdata1;
	word_t    rdata2;
	logic     we;
	reg_idx_t waddr;
	word_t    wdata;

	fetch_stage u_fetch (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_stall    (stall),
		.i_halt     (o_is_halted),
		.i_redirect (redirect),
		.i_target   (target),
		.i_data1    (i_data1),
		.o_read_m1  (o_read_m1),
		.o_address1 (o_address1),
		.o_if       (if_d)
	);

	pipe_latch #(.T(if_id_t)) u_if_id (
		.clk     (clk),
		.i_reset (i_reset),
		.i_stall (stall),
		.i_flush (redirect),
		.i_d     (if_d),
		.o_q     (if_q)
	);

	decode_stage u_decode (
		.i_if         (if_q),
		.i_rdata1     (rdata1),
		.i_rdata2     (rdata2),
		.i_ex_dest    (id_q.dest),
		.i_ex_writes  (id_q.ctrl.valid && id_q.ctrl.reg_write),
		.i_mem_dest   (ex_q.dest),
		.i_mem_writes (ex_q.ctrl.valid && ex_q.ctrl.reg_write),
		.o_raddr1     (raddr1),
		.o_raddr2     (raddr2),
		.o_id         (id_d),
		.o_stall      (stall)
	);

	register_file u_regs (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_raddr1 (raddr1),
		.i_raddr2 (raddr2),
		.i_we     (we),
		.i_waddr  (waddr),
		.i_wdata  (wdata),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2)
	);

	// a stalled decode leaves a bubble in execute
	pipe_latch #(.T(id_ex_t)) u_id_ex (
		.clk     (clk),
		.i_reset (i_reset),
		.i_stall (1'b0),
		.i_flush (redirect || stall),
		.i_d     (id_d),
		.o_q     (id_q)
	);

	execute_stage u_execute (
		.i_id       (id_q),
		.o_ex       (ex_d),
		.o_redirect (redirect),
		.o_target   (target)
	);

	pipe_latch #(.T(ex_mem_t)) u_ex_mem (
		.clk     (clk),
		.i_reset (i_reset),
		.i_stall (1'b0),
		.i_flush (1'b0),
		.i_d     (ex_d),
		.o_q     (ex_q)
	);

	pipe_latch #(.T(mem_wb_t)) u_mem_wb (
		.clk     (clk),
		.i_reset (i_reset),
		.i_stall (1'b0),
		.i_flush (1'b0),
		.i_d     (wb_d),
		.o_q     (wb_q)
	);

	writeback_stage u_writeback (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_mem         (ex_q),
		.i_data2       (i_data2),
		.i_wb          (wb_q),
		.o_read_m2     (o_read_m2),
		.o_write_m2    (o_write_m2),
		.o_address2    (o_address2),
		.o_wdata2      (o_wdata2),
		.o_mem_wb      (wb_d),
		.o_we          (we),
		.o_waddr       (waddr),
		.o_wdata       (wdata),
		.o_num_inst    (o_num_inst),
		.o_output_port (o_output_port),
		.o_is_halted   (o_is_halted)
	);

endmodule

// ==== tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int PROG_MAX = 60;
localparam word_t HLT_WORD = {4'd15, 6'd0, 6'd29};

logic [31:0] rng_state;
word_t       prog [256];
word_t       model_mem [256];
int          prog_len;
word_t       exp_out [$];
word_t       exp_st_addr [$];
word_t       exp_st_data [$];
word_t       exp_count;

// linear congruential generator, upper bits are the better ones
function automatic logic [15:0] next_rand();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state[30:15];
endfunction

// data memory contents, different for each run
function automatic word_t mem_fill(input int addr, input int run);
	return word_t'((addr * 16'h02c9) ^ (addr << 11) ^ (run * 16'h1357) ^ 16'h6e1b);
endfunction

task automatic emit(input word_t w);
	prog[prog_len] = w;
	prog_len++;
endtask

// straight-line instructions only
task automatic emit_filler();
	logic [15:0] r;
	logic [1:0]  rs;
	logic [1:0]  rt;
	logic [1:0]  rd;
	logic [7:0]  imm;
	int          kind;
	r = next_rand();
	rs = r[1:0];
	rt = r[3:2];
	rd = r[5:4];
	imm = r[13:6];
	kind = next_rand() % 12;
	case (kind)
		0: emit({4'd15, rs, rt, rd, 6'd0});
		1: emit({4'd15, rs, rt, rd, 6'd1});
		2: emit({4'd15, rs, rt, rd, 6'd2});
		3: emit({4'd15, rs, rt, rd, 6'd3});
		4: emit({4'd15, rs, rt, rd, 6'd4});
		5: emit({4'd4, rs, rt, imm});
		6: emit({4'd5, rs, rt, imm});
		7: emit({4'd6, rs, rt, imm});
		8: emit({4'd7, rs, rt, imm});
		9: emit({4'd8, rs, rt, imm});
		default: emit({4'd15, rs, rt, rd, 6'd28});
	endcase
endtask

// forward transfer, skipped slots are filled so targets land on a boundary
task automatic emit_control();
	logic [15:0] r;
	int          kind;
	int          k;
	int          t;
	logic [1:0]  rx;
	r = next_rand();
	kind = next_rand() % 5;
	k = next_rand() % 4;
	rx = r[5:4];
	case (kind)
		0: emit({4'd0, r[1:0], r[3:2], 8'(k)});
		1: emit({4'd1, r[1:0], r[3:2], 8'(k)});
		2: emit({4'd9, 12'(prog_len + 1 + k)});
		3: emit({4'd10, 12'(prog_len + 1 + k)});
		default: begin
			t = prog_len + 3 + k;
			emit({4'd6, 2'd0, rx, 8'(t >> 8)});
			emit({4'd5, rx, rx, 8'(t & 255)});
			emit({4'd15, rx, 2'd0, 2'd0, 6'd25});
		end
	endcase
	repeat (k) emit_filler();
endtask

task automatic generate_program();
	for (int i = 0; i < 256; i++) begin
		prog[i] = HLT_WORD;
	end
	prog_len = 0;
	while (prog_len < PROG_MAX - 8) begin
		if (next_rand() % 4 == 0) begin
			emit_control();
		end else begin
			emit_filler();
		end
	end
	emit(HLT_WORD);
endtask

// sequential reference, one instruction per step
task automatic run_model(input int run);
	word_t       regs [4];
	word_t       pc;
	word_t       npc;
	word_t       ins;
	word_t       simm;
	word_t       addr;
	word_t       last;
	logic [3:0]  op;
	logic [1:0]  rs;
	logic [1:0]  rt;
	logic [1:0]  rd;
	int          count;
	bit          halted;
	for (int i = 0; i < 4; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < 256; i++) begin
		model_mem[i] = mem_fill(i, run);
	end
	exp_out.delete();
	exp_st_addr.delete();
	exp_st_data.delete();
	pc = '0;
	last = '0;
	count = 0;
	halted = 0;
	while (!halted && count < 1000) begin
		ins = prog[pc[7:0]];
		count++;
		npc = pc + 16'd1;
		op = ins[15:12];
		rs = ins[11:10];
		rt = ins[9:8];
		rd = ins[7:6];
		simm = {{8{ins[7]}}, ins[7:0]};
		addr = regs[rs] + simm;
		case (op)
			4'd0: if (regs[rs] != regs[rt]) npc = pc + 16'd1 + simm;
			4'd1: if (regs[rs] == regs[rt]) npc = pc + 16'd1 + simm;
			4'd4: regs[rt] = regs[rs] + simm;
			4'd5: regs[rt] = regs[rs] | {8'd0, ins[7:0]};
			4'd6: regs[rt] = {ins[7:0], 8'd0};
			4'd7: regs[rt] = model_mem[addr[7:0]];
			4'd8: begin
				model_mem[addr[7:0]] = regs[rt];
				exp_st_addr.push_back(addr);
				exp_st_data.push_back(regs[rt]);
			end
			4'd9: npc = {npc[15:12], ins[11:0]};
			4'd10: begin
				regs[2] = pc + 16'd1;
				npc = {npc[15:12], ins[11:0]};
			end
			default: begin
				case (ins[5:0])
					6'd0: regs[rd] = regs[rs] + regs[rt];
					6'd1: regs[rd] = regs[rs] - regs[rt];
					6'd2: regs[rd] = regs[rs] & regs[rt];
					6'd3: regs[rd] = regs[rs] | regs[rt];
					6'd4: regs[rd] = ~regs[rs];
					6'd25: npc = regs[rs];
					6'd28: begin
						// the port only shows a change of value
						if (regs[rs] != last) begin
							exp_out.push_back(regs[rs]);
							last = regs[rs];
						end
					end
					default: halted = 1;
				endcase
			end
		endcase
		pc = npc;
	end
	exp_count = word_t'(count);
endtask

`endif

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	`include "tb_isa_model.svh"

	localparam real CLK_PERIOD = 100.0;
	localparam int  RESET_CYCLES = 8;
	localparam int  NUM_RUNS = 3;

	logic  clk;
	logic  reset;
	logic  read_m1;
	word_t address1;
	word_t data1;
	logic  read_m2;
	logic  write_m2;
	word_t address2;
	word_t data2;
	word_t wdata2;
	word_t num_inst;
	word_t output_port;
	logic  is_halted;

	word_t data_mem [256];
	word_t prev_out;

	cpu_core dut_i (
		.clk           (clk),
		.i_reset       (reset),
		.o_read_m1     (read_m1),
		.o_address1    (address1),
		.i_data1       (data1),
		.o_read_m2     (read_m2),
		.o_write_m2    (write_m2),
		.o_address2    (address2),
		.i_data2       (data2),
		.o_wdata2      (wdata2),
		.o_num_inst    (num_inst),
		.o_output_port (output_port),
		.o_is_halted   (is_halted)
	);

	// both memories answer in the same cycle
	assign data1 = prog[address1[7:0]];
	// a data read without o_read_m2 gets the complement
	assign data2 = read_m2 ? data_mem[address2[7:0]] : ~data_mem[address2[7:0]];

	always @(posedge clk) begin
		if (write_m2) begin
			data_mem[address2[7:0]] <= wdata2;
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_output(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: o_output_port expected %h got %h", $time, exp, got);
			stop_with_failure();
		end
	endtask

	task automatic check_store(input word_t got_addr, input word_t got_data,
			input word_t exp_addr, input word_t exp_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			$display("Fail at %0t: o_address2/o_wdata2 expected %h/%h got %h/%h",
				$time, exp_addr, exp_data, got_addr, got_data);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: o_num_inst expected %h got %h", $time, exp, got);
			stop_with_failure();
		end
	endtask

	// outputs are sampled half a cycle away from the active edge
	always @(negedge clk) begin
		if (reset) begin
			prev_out = '0;
		end else begin
			if (output_port !== prev_out) begin
				if (exp_out.size() == 0) begin
					$display("output port changed at %0t with no output expected", $time);
					stop_with_failure();
				end else begin
					check_output(output_port, exp_out.pop_front());
				end
				prev_out = output_port;
			end
			if (write_m2) begin
				if (exp_st_addr.size() == 0) begin
					$display("store at %0t with no store expected", $time);
					stop_with_failure();
				end else begin
					check_store(address2, wdata2, exp_st_addr.pop_front(),
						exp_st_data.pop_front());
				end
			end
		end
	end

	initial begin
		#(NUM_RUNS * (PROG_MAX * 20 + RESET_CYCLES + 20) * CLK_PERIOD);
		$display("timeout at %0t, the processor never halted", $time);
		stop_with_failure();
	end

	initial begin
		reset = 1'b1;
		prev_out = '0;
		rng_state = 32'hd725;
		for (int run = 0; run < NUM_RUNS; run++) begin
			@(posedge clk);
			reset <= 1'b1;
			generate_program();
			run_model(run);
			for (int i = 0; i < 256; i++) begin
				data_mem[i] = mem_fill(i, run);
			end
			repeat (RESET_CYCLES - 1) @(posedge clk);
			@(negedge clk);
			if (read_m1 !== 1'b0 || read_m2 !== 1'b0 || write_m2 !== 1'b0 ||
					is_halted !== 1'b0) begin
				$display("memory read, store or halt active during reset at %0t", $time);
				stop_with_failure();
			end
			check_count(num_inst, '0);
			check_output(output_port, '0);
			@(posedge clk);
			reset <= 1'b0;
			wait (is_halted === 1'b1);
			@(negedge clk);
			check_count(num_inst, exp_count);
			if (exp_out.size() != 0 || exp_st_addr.size() != 0) begin
				$display("halted with %0d outputs and %0d stores still expected",
					exp_out.size(), exp_st_addr.size());
				stop_with_failure();
			end
			// nothing retires once halted
			repeat (10) begin
				@(negedge clk);
				check_count(num_inst, exp_count);
			end
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
cpu_pkg.sv
pipe_latch.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
writeback_stage.sv
cpu_core.sv
tb_cpu.sv
